// File: hw/spi_defs.svh
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// size of each bit memory in bytes
`define SPI_MEM_BYTES 2

`define SPI_CONF_REGS 8
`define SPI_ADDR_TX_BASE (`SPI_CONF_REGS)
`define SPI_ADDR_RX_BASE (`SPI_ADDR_TX_BASE + `SPI_MEM_BYTES)
`define SPI_DEF_BITS (8 * `SPI_MEM_BYTES)

`define SPI_ADDR_RST 0     // write only, soft reset
`define SPI_ADDR_START 1   // write starts, read returns done
`define SPI_ADDR_BITS_HI 3
`define SPI_ADDR_BITS_LO 4
`define SPI_ADDR_WAIT_HI 5
`define SPI_ADDR_WAIT_LO 6
`define SPI_ADDR_REPEAT 7
`endif

// File: hw/spi_pkg.sv
package spi_pkg;

  // one bus cycle, write strobe is a single clock wide
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        we;
  } bus_req_t;

  // frame setup as used by the sequencer
  typedef struct packed {
    logic [15:0] bit_cnt;   // active bits per frame
    logic [15:0] wait_cnt;  // idle cycles after the active bits
    logic [7:0]  rep_cnt;   // number of frames, zero runs forever
  } spi_conf_t;

  // per-cycle frame control from the sequencer
  typedef struct packed {
    logic        en;         // internal enable, high for the active bits
    logic        capture;    // sample SDO into the receive memory
    logic [15:0] bit_index;  // serial bit position within the pattern
    logic        load;       // end of frame, one cycle wide
  } frame_ctl_t;

endpackage

// File: hw/spi_bit_mem.sv
`include "spi_defs.svh"

module spi_bit_mem #(
  parameter int BASE = 0
) (
  input  logic        SPI_CLK,
  input  logic        bus_we,
  input  logic [15:0] bus_addr,
  input  logic [7:0]  bus_wdata,
  output logic [7:0]  bus_rdata,
  input  logic        ser_we,
  input  logic [15:0] ser_index,
  input  logic        ser_wbit,
  output logic        ser_rbit
);

  localparam int AW = (`SPI_MEM_BYTES > 1) ? $clog2(`SPI_MEM_BYTES) : 1;

  logic [7:0]  mem [`SPI_MEM_BYTES];
  logic [15:0] bus_off;
  logic        bus_ok;
  logic [12:0] ser_byte;
  logic [2:0]  ser_bit;
  logic        ser_ok;

  assign bus_off = bus_addr - 16'(BASE);  // addresses below the base wrap out of range
  assign bus_ok  = bus_off < `SPI_MEM_BYTES;

  // serial bit k sits in byte k/8, counted from the top bit down
  assign ser_byte = ser_index[15:3];
  assign ser_bit  = ~ser_index[2:0];
  assign ser_ok   = ser_byte < `SPI_MEM_BYTES;

  assign bus_rdata = bus_ok ? mem[bus_off[AW-1:0]] : 8'd0;
  assign ser_rbit  = ser_ok ? mem[ser_byte[AW-1:0]][ser_bit] : 1'b0;

  always_ff @(posedge SPI_CLK) begin
    if (bus_we && bus_ok) begin
      mem[bus_off[AW-1:0]] <= bus_wdata;
    end
    if (ser_we && ser_ok) begin
      mem[ser_byte[AW-1:0]][ser_bit] <= ser_wbit;
    end
  end

endmodule

// File: hw/spi_regs.sv
`include "spi_defs.svh"

module spi_regs
  import spi_pkg::*;
(
  input  logic      SPI_CLK,
  input  logic      RST_SYNC,
  input  bus_req_t  bus,
  input  logic [7:0] tx_byte,
  input  logic [7:0] rx_byte,
  input  logic      done,
  output logic [7:0] rdata,
  output spi_conf_t conf,
  output logic      start,
  output logic      seq_clr,
  output logic      tx_we
);

  logic soft_rst;
  logic tx_sel;
  logic rx_sel;

  assign soft_rst = bus.we && (bus.addr == `SPI_ADDR_RST);
  assign start    = bus.we && (bus.addr == `SPI_ADDR_START);
  assign seq_clr  = RST_SYNC || soft_rst;  // soft reset clears the same state as reset

  assign tx_sel = (bus.addr >= `SPI_ADDR_TX_BASE) && (bus.addr < `SPI_ADDR_RX_BASE);
  assign rx_sel = (bus.addr >= `SPI_ADDR_RX_BASE) &&
                  (bus.addr < `SPI_ADDR_RX_BASE + `SPI_MEM_BYTES);
  assign tx_we  = bus.we && tx_sel;

  always_ff @(posedge SPI_CLK) begin
    if (seq_clr) begin
      conf.bit_cnt  <= 16'(`SPI_DEF_BITS);
      conf.wait_cnt <= 16'd0;
      conf.rep_cnt  <= 8'd1;
    end else if (bus.we) begin
      case (bus.addr)
        `SPI_ADDR_BITS_HI: begin
          conf.bit_cnt[15:8] <= bus.wdata;
        end
        `SPI_ADDR_BITS_LO: begin
          conf.bit_cnt[7:0] <= bus.wdata;
        end
        `SPI_ADDR_WAIT_HI: begin
          conf.wait_cnt[15:8] <= bus.wdata;
        end
        `SPI_ADDR_WAIT_LO: begin
          conf.wait_cnt[7:0] <= bus.wdata;
        end
        `SPI_ADDR_REPEAT: begin
          conf.rep_cnt <= bus.wdata;
        end
        default: begin
        end
      endcase
    end
  end

  // address 0 and 2 fall through to zero
  always_comb begin
    rdata = 8'd0;
    if (tx_sel) begin
      rdata = tx_byte;
    end else if (rx_sel) begin
      rdata = rx_byte;
    end else if (bus.addr < `SPI_CONF_REGS) begin
      case (bus.addr)
        `SPI_ADDR_START: begin
          rdata = {7'd0, done};
        end
        `SPI_ADDR_BITS_HI: begin
          rdata = conf.bit_cnt[15:8];
        end
        `SPI_ADDR_BITS_LO: begin
          rdata = conf.bit_cnt[7:0];
        end
        `SPI_ADDR_WAIT_HI: begin
          rdata = conf.wait_cnt[15:8];
        end
        `SPI_ADDR_WAIT_LO: begin
          rdata = conf.wait_cnt[7:0];
        end
        `SPI_ADDR_REPEAT: begin
          rdata = conf.rep_cnt;
        end
        default: begin
          rdata = 8'd0;
        end
      endcase
    end
  end

endmodule

// File: hw/spi_sequencer.sv
module spi_sequencer
  import spi_pkg::*;
(
  input  logic       SPI_CLK,
  input  logic       seq_clr,
  input  logic       start,
  input  spi_conf_t  conf,
  output frame_ctl_t frame,
  output logic       done
);

  logic [15:0] cnt;       // 1 .. bits+wait while a frame runs, 0 when idle
  logic [7:0]  rep_cnt;   // number of the frame in progress
  logic        en;
  logic [15:0] stop_cnt;
  logic        at_stop;
  logic        at_end;
  logic        final_frame;
  logic        rep_start;
  logic [2:0]  ld_sh;
  logic [2:0]  last_sh;

  assign stop_cnt    = conf.bit_cnt + conf.wait_cnt;
  assign at_stop     = (cnt != 16'd0) && (cnt >= stop_cnt);
  assign at_end      = en && (cnt >= conf.bit_cnt);  // last active cycle
  assign final_frame = (conf.rep_cnt != 8'd0) && (rep_cnt >= conf.rep_cnt);
  assign rep_start   = at_stop && !final_frame;

  always_ff @(posedge SPI_CLK) begin
    if (seq_clr) begin
      cnt <= 16'd0;
      en  <= 1'b0;
    end else if (start || rep_start) begin
      cnt <= 16'd1;  // a start in the middle of a frame restarts it
      en  <= 1'b1;
    end else begin
      if (at_end || at_stop) begin
        en <= 1'b0;
      end
      if (at_stop) begin
        cnt <= 16'd0;
      end else if (cnt != 16'd0) begin
        cnt <= cnt + 16'd1;
      end
    end
  end

  always_ff @(posedge SPI_CLK) begin
    if (seq_clr || start) begin
      rep_cnt <= 8'd1;
    end else if (at_stop) begin
      rep_cnt <= rep_cnt + 8'd1;  // wraps harmlessly when repeating forever
    end
  end

  // The end of the active bits travels three cycles before it becomes the load
  // pulse. This keeps one load per frame even when the wait count is zero and
  // the enable never drops between repeats
  always_ff @(posedge SPI_CLK) begin
    if (seq_clr) begin
      ld_sh <= 3'd0;
    end else begin
      ld_sh <= {ld_sh[1:0], at_end};
    end
  end

  always_ff @(posedge SPI_CLK) begin
    if (seq_clr || start) begin
      last_sh <= 3'd0;
    end else begin
      last_sh <= {last_sh[1:0], at_end && final_frame};
    end
  end

  always_ff @(posedge SPI_CLK) begin
    if (seq_clr || start) begin
      done <= 1'b0;
    end else if (ld_sh[2] && last_sh[2]) begin
      done <= 1'b1;  // rises with the last SLD at the pins
    end
  end

  assign frame.en        = en;
  assign frame.capture   = en;  // SCLK rises at the end of every enabled cycle
  assign frame.bit_index = cnt - 16'd1;
  assign frame.load      = ld_sh[2];

endmodule

// File: hw/spi_pins.sv
module spi_pins
  import spi_pkg::*;
(
  input  logic       SPI_CLK,
  input  logic       seq_clr,
  input  frame_ctl_t frame,
  input  logic       tx_bit,
  output logic       SCLK,
  output logic       SDI,
  output logic       SEN,
  output logic       SLD
);

  // data and enable change while the clock is low, half a cycle before SCLK rises
  always_ff @(negedge SPI_CLK) begin
    if (seq_clr) begin
      SDI <= 1'b0;
      SEN <= 1'b0;
    end else begin
      SDI <= frame.en & tx_bit;
      SEN <= frame.en;
    end
  end

  always_ff @(posedge SPI_CLK) begin
    if (seq_clr) begin
      SLD <= 1'b0;
    end else begin
      SLD <= frame.load;
    end
  end

  assign SCLK = SPI_CLK & SEN;  // SEN only moves while SPI_CLK is low, so no glitch

endmodule

// File: hw/spi_master.sv
`include "spi_defs.svh"

module spi_master
  import spi_pkg::*;
(
  input  logic       SPI_CLK,
  input  logic       RST_SYNC,
  input  bus_req_t   bus,
  input  logic       SDO,
  output logic [7:0] rdata,
  output logic       SCLK,
  output logic       SDI,
  output logic       SEN,
  output logic       SLD
);

  spi_conf_t  conf;
  frame_ctl_t frame;
  logic       start;
  logic       seq_clr;
  logic       tx_we;
  logic       done;
  logic [7:0] tx_byte;
  logic [7:0] rx_byte;
  logic       tx_bit;

  spi_regs u_regs (
    .SPI_CLK (SPI_CLK),
    .RST_SYNC(RST_SYNC),
    .bus     (bus),
    .tx_byte (tx_byte),
    .rx_byte (rx_byte),
    .done    (done),
    .rdata   (rdata),
    .conf    (conf),
    .start   (start),
    .seq_clr (seq_clr),
    .tx_we   (tx_we)
  );

  // transmit pattern, written from the bus and read bit by bit
  spi_bit_mem #(.BASE(`SPI_ADDR_TX_BASE)) tx_mem (
    .SPI_CLK  (SPI_CLK),
    .bus_we   (tx_we),
    .bus_addr (bus.addr),
    .bus_wdata(bus.wdata),
    .bus_rdata(tx_byte),
    .ser_we   (1'b0),
    .ser_index(frame.bit_index),
    .ser_wbit (1'b0),
    .ser_rbit (tx_bit)
  );

  // receive capture, filled from SDO and read back on the bus only
  spi_bit_mem #(.BASE(`SPI_ADDR_RX_BASE)) rx_mem (
    .SPI_CLK  (SPI_CLK),
    .bus_we   (1'b0),
    .bus_addr (bus.addr),
    .bus_wdata(8'd0),
    .bus_rdata(rx_byte),
    .ser_we   (frame.capture),
    .ser_index(frame.bit_index),
    .ser_wbit (SDO),
    .ser_rbit ()
  );

  spi_sequencer u_seq (
    .SPI_CLK(SPI_CLK),
    .seq_clr(seq_clr),
    .start  (start),
    .conf   (conf),
    .frame  (frame),
    .done   (done)
  );

  spi_pins u_pins (
    .SPI_CLK(SPI_CLK),
    .seq_clr(seq_clr),
    .frame  (frame),
    .tx_bit (tx_bit),
    .SCLK   (SCLK),
    .SDI    (SDI),
    .SEN    (SEN),
    .SLD    (SLD)
  );

endmodule

// File: tb/spi_master_tb.sv
`include "spi_defs.svh"

module spi_master_tb
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 40;
  localparam int MAX_BITS    = 8 * `SPI_MEM_BYTES;
  localparam int MAX_WAIT    = 15;
  localparam int MAX_REP     = 3;
  localparam int SINGLE_RUNS = 6;
  localparam int REPEAT_RUNS = 6;
  localparam int RUN_CYCLES  = MAX_REP * (MAX_BITS + MAX_WAIT + 2) + 40;
  localparam int WATCHDOG_CYCLES = (SINGLE_RUNS + REPEAT_RUNS) * RUN_CYCLES + 400;

  logic       SPI_CLK = 1'b0;
  logic       RST_SYNC;
  bus_req_t   bus;
  logic       SDO;
  logic [7:0] rdata;
  logic       SCLK;
  logic       SDI;
  logic       SEN;
  logic       SLD;

  integer     seed = 82;
  int         sld_count = 0;
  logic       sdi_seen[$];
  logic       sdo_seen[$];
  logic [7:0] tx_model[`SPI_MEM_BYTES];
  logic [7:0] rx_model[`SPI_MEM_BYTES];

  spi_master dut (
    .SPI_CLK (SPI_CLK),
    .RST_SYNC(RST_SYNC),
    .bus     (bus),
    .SDO     (SDO),
    .rdata   (rdata),
    .SCLK    (SCLK),
    .SDI     (SDI),
    .SEN     (SEN),
    .SLD     (SLD)
  );

  always #(CLK_PERIOD / 2) SPI_CLK = ~SPI_CLK;

  function automatic int random_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // pattern bit k in transmit order with the top bit of each byte first
  function automatic logic tx_bit_at(input int k);
    return tx_model[k / 8][7 - (k % 8)];
  endfunction

  always @(negedge SCLK) begin
    #5;
    SDO = 1'(random_below(2));  // slave shifts its next bit out
  end

  always @(posedge SCLK) begin
    sdi_seen.push_back(SDI);
    sdo_seen.push_back(SDO);
  end

  always @(negedge SPI_CLK) begin
    if (SLD === 1'b1) begin
      sld_count++;
    end
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_failure("watchdog expired before the tests finished");
  end

  // bus tasks begin and end 2 ns after a rising clock edge
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge SPI_CLK);
      #2;
    end
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    bus.addr  = addr;
    bus.wdata = data;
    bus.we    = 1'b1;
    @(posedge SPI_CLK);
    #2;
    bus.we = 1'b0;
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
    bus.addr = addr;
    bus.we   = 1'b0;
    @(negedge SPI_CLK);
    #1;
    data = rdata;
    @(posedge SPI_CLK);
    #2;
  endtask

  task automatic check_read(input logic [15:0] addr, input logic [7:0] expected);
    logic [7:0] data;
    bus_read(addr, data);
    check_equal($sformatf("rdata@0x%0h", addr), data, expected);
  endtask

  task automatic check_defaults();
    check_read(`SPI_ADDR_BITS_HI, 8'(`SPI_DEF_BITS >> 8));
    check_read(`SPI_ADDR_BITS_LO, 8'(`SPI_DEF_BITS));
    check_read(`SPI_ADDR_WAIT_HI, 8'h00);
    check_read(`SPI_ADDR_WAIT_LO, 8'h00);
    check_read(`SPI_ADDR_REPEAT, 8'h01);
    check_read(`SPI_ADDR_START, 8'h00);  // done is low
  endtask

  // done is polled once per cycle and the SLD count must lag until it rises
  task automatic wait_for_done(input int rep, input int limit);
    logic [7:0] data;
    int cycles;
    cycles = 0;
    data   = 8'h00;
    while (data[0] !== 1'b1) begin
      if (cycles >= limit) begin
        stop_with_failure("done flag did not rise in time");
      end
      bus_read(`SPI_ADDR_START, data);
      if (data[0] === 1'b1) begin
        check_equal("sld_count at done", sld_count, rep);
      end else if (sld_count >= rep) begin
        stop_with_failure("done still low after the last SLD pulse");
      end
      cycles++;
    end
  endtask

  task automatic run_transfer(input int bits, input int wait_cnt, input int rep);
    int i;
    int k;
    int first;
    for (i = 0; i < `SPI_MEM_BYTES; i++) begin
      tx_model[i] = 8'(random_below(256));
      bus_write(16'(`SPI_ADDR_TX_BASE + i), tx_model[i]);
    end
    bus_write(`SPI_ADDR_BITS_HI, 8'(bits >> 8));
    bus_write(`SPI_ADDR_BITS_LO, 8'(bits));
    bus_write(`SPI_ADDR_WAIT_HI, 8'(wait_cnt >> 8));
    bus_write(`SPI_ADDR_WAIT_LO, 8'(wait_cnt));
    bus_write(`SPI_ADDR_REPEAT, 8'(rep));
    sdi_seen.delete();
    sdo_seen.delete();
    sld_count = 0;
    bus_write(`SPI_ADDR_START, 8'h00);
    wait_for_done(rep, rep * (bits + wait_cnt + 2) + 20);
    idle_cycles(10);
    check_equal("sld_count", sld_count, rep);
    check_equal("sclk_rises", sdi_seen.size(), bits * rep);
    for (k = 0; k < bits * rep; k++) begin
      check_equal($sformatf("sdi[%0d]", k), sdi_seen[k], tx_bit_at(k % bits));
    end
    first = (rep - 1) * bits;  // only the last frame stays in the receive memory
    for (k = 0; k < bits; k++) begin
      rx_model[k / 8][7 - (k % 8)] = sdo_seen[first + k];
    end
    for (i = 0; i < `SPI_MEM_BYTES; i++) begin
      check_read(16'(`SPI_ADDR_RX_BASE + i), rx_model[i]);
    end
  endtask

  initial begin
    logic [15:0] addr;
    logic [7:0]  value;
    int          bits;
    int          i;
    int          polls;
    RST_SYNC = 1'b1;
    bus      = '0;
    SDO      = 1'b0;
    repeat (8) @(posedge SPI_CLK);
    #2;
    RST_SYNC = 1'b0;

    check_equal("SEN", SEN, 1'b0);
    check_equal("SLD", SLD, 1'b0);
    check_defaults();

    // configuration and transmit bytes read back as written and address 2 stays zero
    for (i = 0; i < 20; i++) begin
      addr  = 16'(`SPI_ADDR_BITS_HI +
                  random_below(`SPI_ADDR_RX_BASE - `SPI_ADDR_BITS_HI));
      value = 8'(random_below(256));
      bus_write(addr, value);
      check_read(addr, value);
    end
    bus_write(16'd2, 8'(random_below(255) + 1));
    check_read(16'd2, 8'h00);

    // the first frame uses every bit so the whole receive memory is known
    for (i = 0; i < SINGLE_RUNS; i++) begin
      bits = (i == 0) ? MAX_BITS : 1 + random_below(MAX_BITS);
      run_transfer(bits, random_below(MAX_WAIT + 1), 1);
    end
    for (i = 0; i < REPEAT_RUNS; i++) begin
      bits = 1 + random_below(MAX_BITS);
      run_transfer(bits, random_below(MAX_WAIT + 1), 1 + random_below(MAX_REP));
    end

    // soft reset in the middle of a long transfer
    check_read(`SPI_ADDR_START, 8'h01);
    bus_write(`SPI_ADDR_BITS_LO, 8'd5);
    bus_write(`SPI_ADDR_WAIT_LO, 8'd9);
    bus_write(`SPI_ADDR_REPEAT, 8'd3);
    bus_write(`SPI_ADDR_START, 8'h00);
    polls = 0;
    while (SEN !== 1'b1) begin
      if (polls > 10) begin
        stop_with_failure("SEN did not rise after the start write");
      end
      idle_cycles(1);
      polls++;
    end
    idle_cycles(2);
    bus_write(`SPI_ADDR_RST, 8'(random_below(256)));
    idle_cycles(1);
    check_equal("SEN after soft reset", SEN, 1'b0);
    check_defaults();
    idle_cycles(20);
    check_equal("SEN idle after soft reset", SEN, 1'b0);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: spi_master

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/spi_pkg.sv
      - hw/spi_bit_mem.sv
      - hw/spi_regs.sv
      - hw/spi_sequencer.sv
      - hw/spi_pins.sv
      - hw/spi_master.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/spi_master_tb.sv

// File: project.f
+incdir+hw
hw/spi_pkg.sv
hw/spi_bit_mem.sv
hw/spi_regs.sv
hw/spi_sequencer.sv
hw/spi_pins.sv
hw/spi_master.sv
tb/spi_master_tb.sv
